// ==== rtl/pmu_pkg.sv ====
package pmu_pkg;

    // Width of a memory word and of a configuration word
    localparam int WORD_W = 32;
    // Word address into the image memory
    localparam int ADDR_W = 8;
    // Width of the keystream seed
    localparam int KEY_W = 32;

    // Image layout in the external memory
    // Word 0 holds the plain payload count N
    // Words 1 to N hold the scrambled payload, first word first
    // Word N+1 holds the XOR of all plaintext payload words
    localparam logic [ADDR_W-1:0] HDR_ADDR = '0;
    localparam logic [ADDR_W-1:0] PAYLOAD_ADDR = HDR_ADDR + 1'b1;

    // Load sequencer states
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        STREAM,
        CHECK,
        DONE,
        FAIL
    } ctrl_state_t;

    // One xorshift step of the keystream
    // Stand-in for a real block cipher
    // Shifts are left 13, right 17, left 5
    function automatic logic [KEY_W-1:0] xorshift32(input logic [KEY_W-1:0] s);
        logic [KEY_W-1:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

endpackage

// ==== rtl/pmu_mem_reader.sv ====
`timescale 1ns/1ns

module pmu_mem_reader (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  logic                       fetch_go_i,
    input  logic [pmu_pkg::ADDR_W-1:0] fetch_count_i,
    output logic [pmu_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                       mem_rd_o,
    input  logic [pmu_pkg::WORD_W-1:0] mem_data_i,
    output logic                       word_req_o,
    input  logic                       word_ack_i,
    output logic [pmu_pkg::WORD_W-1:0] word_data_o,
    output logic                       fetch_done_o
);
    import pmu_pkg::*;

    // Read, wait a cycle for data, hand over, wait for release
    typedef enum logic [2:0] {
        R_IDLE,
        R_READ,
        R_CAPT,
        R_HAND,
        R_REL
    } rd_state_t;

    rd_state_t         state;
    // Address of the checksum word, the last one fetched
    logic [ADDR_W-1:0] last_addr;

    // One-cycle read strobe, data shows up in R_CAPT
    assign mem_rd_o = (state == R_READ);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state        <= R_IDLE;
            mem_addr_o   <= PAYLOAD_ADDR;
            last_addr    <= '0;
            word_req_o   <= 1'b0;
            fetch_done_o <= 1'b0;
        end else begin
            fetch_done_o <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (fetch_go_i) begin
                        mem_addr_o <= PAYLOAD_ADDR;
                        // Checksum follows the N payload words
                        last_addr  <= fetch_count_i + PAYLOAD_ADDR;
                        state      <= R_READ;
                    end
                end
                R_READ: state <= R_CAPT;
                R_CAPT: begin
                    word_req_o <= 1'b1;
                    state      <= R_HAND;
                end
                R_HAND: begin
                    if (word_ack_i) begin
                        word_req_o <= 1'b0;
                        state      <= R_REL;
                    end
                end
                R_REL: begin
                    // Four-phase return to zero before the next word
                    if (!word_ack_i) begin
                        if (mem_addr_o == last_addr) begin
                            fetch_done_o <= 1'b1;
                            state        <= R_IDLE;
                        end else begin
                            mem_addr_o <= mem_addr_o + 1'b1;
                            state      <= R_READ;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Word register, loaded once per fetch
    always_ff @(posedge wb_clk_i) begin
        if (state == R_CAPT) begin
            word_data_o <= mem_data_i;
        end
    end

    // Offered word must hold until the descrambler takes it
    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        word_req_o && !word_ack_i |=> $stable(word_data_o));

endmodule

// ==== rtl/pmu_descrambler.sv ====
`timescale 1ns/1ns

module pmu_descrambler (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  logic                       key_load_i,
    input  logic [pmu_pkg::KEY_W-1:0]  key_i,
    input  logic [pmu_pkg::ADDR_W-1:0] word_count_i,
    input  logic                       word_req_i,
    output logic                       word_ack_o,
    input  logic [pmu_pkg::WORD_W-1:0] word_data_i,
    output logic                       plain_req_o,
    input  logic                       plain_ack_i,
    output logic [pmu_pkg::WORD_W-1:0] plain_data_o,
    output logic [pmu_pkg::WORD_W-1:0] sum_o,
    output logic                       sum_match_o
);
    import pmu_pkg::*;

    logic [KEY_W-1:0]  ks_state;
    logic [KEY_W-1:0]  ks_next;
    logic [WORD_W-1:0] plain_word;
    // Payload words received so far in this load
    logic [ADDR_W-1:0] rx_cnt;
    // One-word skid buffer between input and output
    logic [WORD_W-1:0] buf_data;
    logic              buf_valid;
    logic              is_payload;
    logic              take_payload;
    logic              take_sum;
    logic              move_out;

    // Keystream advances before it is applied
    assign ks_next    = xorshift32(ks_state);
    assign plain_word = word_data_i ^ ks_next;
    assign is_payload = (rx_cnt != word_count_i);

    // Payload word accepted whenever the buffer is free
    assign take_payload = word_req_i && !word_ack_o && is_payload && !buf_valid;
    // Checksum waits until the shifter has drained every payload word
    // so the load ends only with the chain fully written
    assign take_sum = word_req_i && !word_ack_o && !is_payload && !buf_valid &&
                      !plain_req_o && !plain_ack_i;
    // Output stage free and back at zero
    assign move_out = buf_valid && !plain_req_o && !plain_ack_i;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            word_ack_o  <= 1'b0;
            plain_req_o <= 1'b0;
            buf_valid   <= 1'b0;
            rx_cnt      <= '0;
            sum_match_o <= 1'b0;
        end else if (key_load_i) begin
            rx_cnt      <= '0;
            sum_match_o <= 1'b0;
        end else begin
            if (take_payload || take_sum) begin
                word_ack_o <= 1'b1;
            end else if (word_ack_o && !word_req_i) begin
                word_ack_o <= 1'b0;
            end
            if (take_payload) begin
                rx_cnt    <= rx_cnt + 1'b1;
                buf_valid <= 1'b1;
            end
            // Checksum word is consumed here and never sent on
            if (take_sum) begin
                sum_match_o <= (word_data_i == sum_o);
            end
            if (move_out) begin
                buf_valid   <= 1'b0;
                plain_req_o <= 1'b1;
            end else if (plain_req_o && plain_ack_i) begin
                plain_req_o <= 1'b0;
            end
        end
    end

    // Keystream, running XOR and word buffers
    always_ff @(posedge wb_clk_i) begin
        if (key_load_i) begin
            ks_state <= key_i;
            sum_o    <= '0;
        end else begin
            if (take_payload) begin
                ks_state <= ks_next;
                buf_data <= plain_word;
                sum_o    <= sum_o ^ plain_word;
            end
            if (move_out) begin
                plain_data_o <= buf_data;
            end
        end
    end

endmodule

// ==== rtl/pmu_ccff_shifter.sv ====
`timescale 1ns/1ns

module pmu_ccff_shifter (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  logic                       plain_req_i,
    output logic                       plain_ack_o,
    input  logic [pmu_pkg::WORD_W-1:0] plain_data_i,
    output logic                       ccff_data_o,
    output logic                       ccff_shift_o
);
    import pmu_pkg::*;

    localparam int CNT_W = $clog2(WORD_W);

    logic [WORD_W-1:0] shift_q;
    // Index of the bit currently on the data line
    logic [CNT_W-1:0]  bit_cnt;
    logic              shifting;
    logic              load;

    // New word only once the previous handshake has fully closed
    assign load = plain_req_i && !plain_ack_o && !shifting;

    // MSB goes out first, one strobe per bit
    assign ccff_data_o  = shift_q[WORD_W-1];
    assign ccff_shift_o = shifting;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            shifting    <= 1'b0;
            bit_cnt     <= '0;
            plain_ack_o <= 1'b0;
        end else begin
            if (load) begin
                shifting <= 1'b1;
                bit_cnt  <= '0;
            end else if (shifting) begin
                bit_cnt <= bit_cnt + 1'b1;
                // Ack right after the last strobe
                if (bit_cnt == CNT_W'(WORD_W - 1)) begin
                    shifting    <= 1'b0;
                    plain_ack_o <= 1'b1;
                end
            end
            if (plain_ack_o && !plain_req_i) begin
                plain_ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (load) begin
            shift_q <= plain_data_i;
        end else if (shifting) begin
            shift_q <= shift_q << 1;
        end
    end

    // Strobes only while the descrambler still holds its request
    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        ccff_shift_o |-> plain_req_i);

endmodule

// ==== rtl/pmu_ctrl.sv ====
`timescale 1ns/1ns

module pmu_ctrl #(
    parameter int CHAIN_WORDS = 4
) (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  logic                       start_req_i,
    output logic                       start_ack_o,
    input  logic [pmu_pkg::KEY_W-1:0]  key_i,
    output logic [pmu_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                       mem_rd_o,
    input  logic [pmu_pkg::WORD_W-1:0] mem_data_i,
    output logic                       fetch_go_o,
    output logic [pmu_pkg::ADDR_W-1:0] fetch_count_o,
    input  logic                       fetch_done_i,
    output logic                       key_load_o,
    input  logic                       sum_match_i,
    output logic                       busy_o,
    output logic                       locked_o,
    output logic                       error_o,
    output logic                       fpga_rst_o,
    output logic                       fpga_clk_en_o
);
    import pmu_pkg::*;

    ctrl_state_t state;
    // Set in the header cycle where memory data is valid
    logic        hdr_wait;
    logic        hdr_ok;

    // Controller only ever reads the header word
    assign mem_addr_o = HDR_ADDR;
    assign mem_rd_o   = (state == HEADER) && !hdr_wait;
    assign busy_o     = (state == HEADER) || (state == STREAM) || (state == CHECK);

    // Count must fit the chain exactly and the key must be nonzero
    assign hdr_ok = (mem_data_i == WORD_W'(CHAIN_WORDS)) && (key_i != '0);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state         <= IDLE;
            hdr_wait      <= 1'b0;
            start_ack_o   <= 1'b0;
            fetch_go_o    <= 1'b0;
            fetch_count_o <= '0;
            key_load_o    <= 1'b0;
            locked_o      <= 1'b0;
            error_o       <= 1'b0;
            fpga_rst_o    <= 1'b1;
            fpga_clk_en_o <= 1'b0;
        end else begin
            fetch_go_o <= 1'b0;
            key_load_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_req_i && !start_ack_o) begin
                        // Fabric back into reset while it is rewritten
                        locked_o      <= 1'b0;
                        error_o       <= 1'b0;
                        fpga_rst_o    <= 1'b1;
                        fpga_clk_en_o <= 1'b0;
                        hdr_wait      <= 1'b0;
                        state         <= HEADER;
                    end
                end
                HEADER: begin
                    if (!hdr_wait) begin
                        hdr_wait <= 1'b1;
                    end else if (hdr_ok) begin
                        // Reader and descrambler start together
                        fetch_count_o <= mem_data_i[ADDR_W-1:0];
                        fetch_go_o    <= 1'b1;
                        key_load_o    <= 1'b1;
                        state         <= STREAM;
                    end else begin
                        error_o     <= 1'b1;
                        start_ack_o <= 1'b1;
                        state       <= FAIL;
                    end
                end
                STREAM: begin
                    if (fetch_done_i) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    start_ack_o <= 1'b1;
                    if (sum_match_i) begin
                        locked_o      <= 1'b1;
                        fpga_rst_o    <= 1'b0;
                        fpga_clk_en_o <= 1'b1;
                        state         <= DONE;
                    end else begin
                        error_o <= 1'b1;
                        state   <= FAIL;
                    end
                end
                DONE, FAIL: begin
                    // Ack drops once the host releases its request
                    if (!start_req_i) begin
                        start_ack_o <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        !(locked_o && error_o));

endmodule

// ==== rtl/fpga_cfg_chain.sv ====
`timescale 1ns/1ns

module fpga_cfg_chain #(
    parameter int CHAIN_WORDS = 4
) (
    input  logic                                   wb_clk_i,
    input  logic                                   ccff_head_i,
    input  logic                                   ccff_shift_i,
    output logic                                   ccff_tail_o,
    output logic [CHAIN_WORDS*pmu_pkg::WORD_W-1:0] cfg_bits_o
);
    import pmu_pkg::*;

    localparam int CHAIN_BITS = CHAIN_WORDS * WORD_W;

    // Bits enter at the LSB and walk toward the MSB
    // so the first word shifted ends up on top
    always_ff @(posedge wb_clk_i) begin
        if (ccff_shift_i) begin
            cfg_bits_o <= {cfg_bits_o[CHAIN_BITS-2:0], ccff_head_i};
        end
    end

    // Bit that falls off the chain on the next strobe
    assign ccff_tail_o = cfg_bits_o[CHAIN_BITS-1];

endmodule

// ==== rtl/pmu_top.sv ====
`timescale 1ns/1ns

module pmu_top #(
    parameter int CHAIN_WORDS = 4
) (
    input  logic                                   wb_clk_i,
    input  logic                                   rst_i,
    input  logic                                   start_req_i,
    output logic                                   start_ack_o,
    input  logic [pmu_pkg::KEY_W-1:0]              key_i,
    output logic [pmu_pkg::ADDR_W-1:0]             mem_addr_o,
    output logic                                   mem_rd_o,
    input  logic [pmu_pkg::WORD_W-1:0]             mem_data_i,
    output logic                                   busy_o,
    output logic                                   locked_o,
    output logic                                   error_o,
    output logic                                   fpga_rst_o,
    output logic                                   fpga_clk_en_o,
    output logic                                   ccff_tail_o,
    output logic [CHAIN_WORDS*pmu_pkg::WORD_W-1:0] cfg_bits_o
);
    import pmu_pkg::*;

    // Memory ports of the two readers
    logic [ADDR_W-1:0] ctrl_addr;
    logic              ctrl_rd;
    logic [ADDR_W-1:0] rdr_addr;
    logic              rdr_rd;
    // Controller to datapath
    logic              fetch_go;
    logic [ADDR_W-1:0] fetch_count;
    logic              fetch_done;
    logic              key_load;
    logic              sum_match;
    // Reader to descrambler
    logic              word_req;
    logic              word_ack;
    logic [WORD_W-1:0] word_data;
    // Descrambler to shifter
    logic              bit_req;
    logic              bit_ack;
    logic [WORD_W-1:0] plain_data;
    // Shifter to chain
    logic              ccff_data;
    logic              ccff_shift;

    // Controller owns memory only during its header read
    assign mem_rd_o   = ctrl_rd | rdr_rd;
    assign mem_addr_o = ctrl_rd ? ctrl_addr : rdr_addr;

    pmu_ctrl #(
        .CHAIN_WORDS (CHAIN_WORDS)
    ) u_ctrl (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .start_req_i   (start_req_i),
        .start_ack_o   (start_ack_o),
        .key_i         (key_i),
        .mem_addr_o    (ctrl_addr),
        .mem_rd_o      (ctrl_rd),
        .mem_data_i    (mem_data_i),
        .fetch_go_o    (fetch_go),
        .fetch_count_o (fetch_count),
        .fetch_done_i  (fetch_done),
        .key_load_o    (key_load),
        .sum_match_i   (sum_match),
        .busy_o        (busy_o),
        .locked_o      (locked_o),
        .error_o       (error_o),
        .fpga_rst_o    (fpga_rst_o),
        .fpga_clk_en_o (fpga_clk_en_o)
    );

    pmu_mem_reader u_reader (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .fetch_go_i    (fetch_go),
        .fetch_count_i (fetch_count),
        .mem_addr_o    (rdr_addr),
        .mem_rd_o      (rdr_rd),
        .mem_data_i    (mem_data_i),
        .word_req_o    (word_req),
        .word_ack_i    (word_ack),
        .word_data_o   (word_data),
        .fetch_done_o  (fetch_done)
    );

    // Running sum left open, only the match flag is consumed
    pmu_descrambler u_descrambler (
        .wb_clk_i     (wb_clk_i),
        .rst_i        (rst_i),
        .key_load_i   (key_load),
        .key_i        (key_i),
        .word_count_i (fetch_count),
        .word_req_i   (word_req),
        .word_ack_o   (word_ack),
        .word_data_i  (word_data),
        .plain_req_o  (bit_req),
        .plain_ack_i  (bit_ack),
        .plain_data_o (plain_data),
        .sum_o        (),
        .sum_match_o  (sum_match)
    );

    pmu_ccff_shifter u_shifter (
        .wb_clk_i     (wb_clk_i),
        .rst_i        (rst_i),
        .plain_req_i  (bit_req),
        .plain_ack_o  (bit_ack),
        .plain_data_i (plain_data),
        .ccff_data_o  (ccff_data),
        .ccff_shift_o (ccff_shift)
    );

    fpga_cfg_chain #(
        .CHAIN_WORDS (CHAIN_WORDS)
    ) u_chain (
        .wb_clk_i     (wb_clk_i),
        .ccff_head_i  (ccff_data),
        .ccff_shift_i (ccff_shift),
        .ccff_tail_o  (ccff_tail_o),
        .cfg_bits_o   (cfg_bits_o)
    );

    // Header read and payload fetch never overlap
    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        !(ctrl_rd && rdr_rd));

endmodule

// ==== verif/pmu_checker.sv ====
`timescale 1ns/1ns

module pmu_checker #(
    parameter int CHAIN_WORDS = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   start_req_i,
    input  logic                                   start_ack_i,
    input  logic [pmu_pkg::ADDR_W-1:0]             mem_addr_i,
    input  logic                                   mem_rd_i,
    input  logic                                   busy_i,
    input  logic                                   locked_i,
    input  logic                                   error_i,
    input  logic                                   fpga_rst_i,
    input  logic                                   fpga_clk_en_i,
    input  logic                                   ccff_tail_i,
    input  logic [CHAIN_WORDS*pmu_pkg::WORD_W-1:0] cfg_bits_i,
    input  logic                                   check_i,
    input  logic                                   exp_locked_i,
    input  logic [CHAIN_WORDS*pmu_pkg::WORD_W-1:0] exp_bits_i,
    input  logic                                   fast_fail_i,
    output int                                     err_cnt_o,
    output int                                     check_cnt_o
);
    import pmu_pkg::*;

    localparam int CHAIN_BITS = CHAIN_WORDS * WORD_W;

    int   err_cnt = 0;
    int   check_cnt = 0;
    // Cycles from request to ack
    int   wait_cnt = 0;
    logic rst_q = 1'b0;
    logic req_q = 1'b0;
    logic ack_q = 1'b0;

    assign err_cnt_o = err_cnt;
    assign check_cnt_o = check_cnt;

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bits(input string name, input logic [CHAIN_BITS-1:0] exp,
                              input logic [CHAIN_BITS-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_rule(input string what);
        err_cnt++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    always @(posedge clk_i) begin
        // Reset values, once the first reset edge is behind us
        if (rst_i && rst_q) begin
            check_bit("start_ack_o", 1'b0, start_ack_i);
            check_bit("busy_o", 1'b0, busy_i);
            check_bit("locked_o", 1'b0, locked_i);
            check_bit("error_o", 1'b0, error_i);
            check_bit("fpga_clk_en_o", 1'b0, fpga_clk_en_i);
            check_bit("mem_rd_o", 1'b0, mem_rd_i);
            check_bit("fpga_rst_o", 1'b1, fpga_rst_i);
        end
        if (!rst_i && !rst_q) begin
            // Four-phase host handshake
            if (start_ack_i && !ack_q && !start_req_i) begin
                report_rule("start_ack_o rose without a pending start_req_i");
            end
            if (!start_ack_i && ack_q && req_q) begin
                report_rule("start_ack_o fell while start_req_i was still high");
            end
            if (req_q && !ack_q && start_req_i && !start_ack_i && !busy_i) begin
                report_rule("busy_o low while a load was in progress");
            end
            if (mem_rd_i && !busy_i) begin
                report_rule("memory read outside a load");
            end
            if (mem_rd_i && (mem_addr_i > ADDR_W'(CHAIN_WORDS + 1))) begin
                report_rule("memory read past the end of the image");
            end
            // Refused header ends the load almost at once
            if (start_ack_i && !ack_q && fast_fail_i && (wait_cnt > 4)) begin
                report_rule($sformatf("header failure took %0d cycles", wait_cnt));
            end
            if (start_req_i && !start_ack_i) begin
                wait_cnt <= wait_cnt + 1;
            end else if (!start_req_i) begin
                wait_cnt <= 0;
            end
        end
        // Outcome of a finished load
        if (check_i) begin
            check_bit("locked_o", exp_locked_i, locked_i);
            check_bit("error_o", !exp_locked_i, error_i);
            check_bit("fpga_rst_o", !exp_locked_i, fpga_rst_i);
            check_bit("fpga_clk_en_o", exp_locked_i, fpga_clk_en_i);
            check_bits("cfg_bits_o", exp_bits_i, cfg_bits_i);
            check_bit("ccff_tail_o", exp_bits_i[CHAIN_BITS-1], ccff_tail_i);
        end
        rst_q <= rst_i;
        req_q <= start_req_i;
        ack_q <= start_ack_i;
    end

endmodule

// ==== verif/tb_pmu.sv ====
`timescale 1ns/1ns

module tb_pmu;
    import pmu_pkg::*;

    localparam int CHAIN_WORDS = 4;
    localparam int CHAIN_BITS = CHAIN_WORDS * WORD_W;
    localparam int NUM_ROWS = 6;
    localparam int RESET_CYCLES = 10;
    // Budget per image word, header and checksum included
    localparam int CYCLES_PER_WORD = 200;
    localparam int WATCHDOG_CYCLES =
        NUM_ROWS * (CHAIN_WORDS + 2) * CYCLES_PER_WORD + RESET_CYCLES;

    // Expected end of a load
    localparam logic [1:0] OUT_OK = 2'd0;
    localparam logic [1:0] OUT_SUM = 2'd1;
    localparam logic [1:0] OUT_HDR = 2'd2;

    // One stimulus row
    typedef struct packed {
        logic [KEY_W-1:0] key;
        logic [7:0]       count;
        logic             corrupt;
        logic [1:0]       outcome;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  start_req;
    logic                  start_ack;
    logic [KEY_W-1:0]      key;
    logic [ADDR_W-1:0]     mem_addr;
    logic                  mem_rd;
    logic [WORD_W-1:0]     mem_data = '0;
    logic                  busy;
    logic                  locked;
    logic                  error;
    logic                  fpga_rst;
    logic                  fpga_clk_en;
    logic                  ccff_tail;
    logic [CHAIN_BITS-1:0] cfg_bits;

    // Image memory and the expected chain contents
    logic [WORD_W-1:0]     mem [256];
    logic [15:0]           lfsr;
    row_t                  rows [NUM_ROWS];
    logic [CHAIN_BITS-1:0] image_bits;
    logic [CHAIN_BITS-1:0] chain_model;
    logic                  check_now;
    logic                  exp_locked;
    logic                  fast_fail;
    int                    err_cnt;
    int                    check_cnt;

    pmu_top #(
        .CHAIN_WORDS (CHAIN_WORDS)
    ) dut (
        .wb_clk_i      (clk),
        .rst_i         (rst),
        .start_req_i   (start_req),
        .start_ack_o   (start_ack),
        .key_i         (key),
        .mem_addr_o    (mem_addr),
        .mem_rd_o      (mem_rd),
        .mem_data_i    (mem_data),
        .busy_o        (busy),
        .locked_o      (locked),
        .error_o       (error),
        .fpga_rst_o    (fpga_rst),
        .fpga_clk_en_o (fpga_clk_en),
        .ccff_tail_o   (ccff_tail),
        .cfg_bits_o    (cfg_bits)
    );

    pmu_checker #(
        .CHAIN_WORDS (CHAIN_WORDS)
    ) u_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .start_req_i   (start_req),
        .start_ack_i   (start_ack),
        .mem_addr_i    (mem_addr),
        .mem_rd_i      (mem_rd),
        .busy_i        (busy),
        .locked_i      (locked),
        .error_i       (error),
        .fpga_rst_i    (fpga_rst),
        .fpga_clk_en_i (fpga_clk_en),
        .ccff_tail_i   (ccff_tail),
        .cfg_bits_i    (cfg_bits),
        .check_i       (check_now),
        .exp_locked_i  (exp_locked),
        .exp_bits_i    (chain_model),
        .fast_fail_i   (fast_fail),
        .err_cnt_o     (err_cnt),
        .check_cnt_o   (check_cnt)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory model, data one cycle after the read strobe
    always @(posedge clk) begin
        if (mem_rd) begin
            mem_data <= mem[mem_addr];
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    // Keystream step: xorshift left 13, right 17, left 5
    function automatic logic [KEY_W-1:0] keystream_next(input logic [KEY_W-1:0] s);
        logic [KEY_W-1:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One LFSR step per plaintext bit
    task automatic draw_word(output logic [WORD_W-1:0] w);
        w = '0;
        for (int b = 0; b < WORD_W; b++) begin
            w = {w[WORD_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Header, scrambled payload, checksum of the plaintext
    task automatic build_image(input row_t row);
        logic [WORD_W-1:0] plain;
        logic [KEY_W-1:0]  ks;
        logic [WORD_W-1:0] sum;
        int                n;
        n = int'(row.count);
        ks = row.key;
        sum = '0;
        image_bits = '0;
        mem[0] = WORD_W'(row.count);
        for (int i = 0; i < n; i++) begin
            draw_word(plain);
            ks = keystream_next(ks);
            mem[i + 1] = plain ^ ks;
            sum = sum ^ plain;
            // First payload word lands at the top of the chain
            if (i < CHAIN_WORDS) begin
                image_bits[(CHAIN_WORDS - 1 - i) * WORD_W +: WORD_W] = plain;
            end
        end
        mem[n + 1] = row.corrupt ? (sum ^ 32'h0000_0100) : sum;
    endtask

    // Full four-phase load of one row
    task automatic run_row(input row_t row);
        build_image(row);
        exp_locked = (row.outcome == OUT_OK);
        fast_fail = (row.outcome == OUT_HDR);
        // Chain is rewritten unless the header is refused
        if (row.outcome != OUT_HDR) begin
            chain_model = image_bits;
        end
        key = row.key;
        start_req = 1'b1;
        do @(negedge clk); while (!start_ack);
        check_now = 1'b1;
        @(negedge clk);
        check_now = 1'b0;
        start_req = 1'b0;
        do @(negedge clk); while (start_ack);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: loads did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        rst = 1'b1;
        start_req = 1'b0;
        key = '0;
        check_now = 1'b0;
        exp_locked = 1'b0;
        fast_fail = 1'b0;
        lfsr = 16'd59;
        image_bits = '0;
        chain_model = '0;
        // Fill depends on every address bit
        for (int a = 0; a < 256; a++) begin
            mem[a] = {8'(a) ^ 8'hA5, ~(8'(a)), 8'(a), 8'(a) ^ 8'h3C};
        end
        // key, count, corrupt checksum, outcome
        rows[0] = '{32'h1234_5678, 8'(CHAIN_WORDS), 1'b0, OUT_OK};
        rows[1] = '{32'h0BAD_F00D, 8'(CHAIN_WORDS), 1'b1, OUT_SUM};
        rows[2] = '{32'hCAFE_0001, 8'(CHAIN_WORDS + 1), 1'b0, OUT_HDR};
        rows[3] = '{32'h0000_0000, 8'(CHAIN_WORDS), 1'b0, OUT_HDR};
        rows[4] = '{32'h1357_9BDF, 8'(CHAIN_WORDS), 1'b0, OUT_OK};
        rows[5] = '{32'h2468_ACE0, 8'(CHAIN_WORDS), 1'b0, OUT_OK};
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            run_row(rows[r]);
        end
        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== pmu.f ====
rtl/pmu_pkg.sv
rtl/pmu_mem_reader.sv
rtl/pmu_descrambler.sv
rtl/pmu_ccff_shifter.sv
rtl/pmu_ctrl.sv
rtl/fpga_cfg_chain.sv
rtl/pmu_top.sv
verif/pmu_checker.sv
verif/tb_pmu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PMU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_pmu -f pmu.f -o sim_pmu \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
# A crash or a failed assertion also marks the run as failed
./obj_dir/sim_pmu > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; } || {
    echo "Simulation passed"
    exit 0
}
